/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fetch_top_tb
FILELIST  = fetch_top.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* fetch_top.f */
+incdir+hdl
hdl/fetch_pkg.sv
hdl/ifu.sv
hdl/imem.sv
hdl/fetch_slot.sv
hdl/flow_retire.sv
hdl/fetch_top.sv
tb/fetch_top_properties.sv
tb/fetch_top_tb.sv

/* hdl/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// first fetch address, also the memory base
`define RESET_PC 32'h30000000

// instruction memory depth in words
`define IMEM_WORDS 64

// word index width for the memory
`define IMEM_IDX_W 6

// cycles of arvalid before arready
`define IMEM_WAIT 2

// opcodes
`define OP_JAL 7'b1101111
`define OP_SYSTEM 7'b1110011

// full system words
`define INST_ECALL 32'h00000073
`define INST_MRET 32'h30200073

`endif

/* hdl/fetch_pkg.sv */
package fetch_pkg;

    // byte address: pc, snpc, mtvec, mepc
    typedef logic [31:0] addr_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // redirect from retire back to fetch
    // {excp_flush, xret_flush, jmp_flag, jmp_target[31:0]}
    typedef logic [34:0] redirect_t;

    // retire side sequencing
    typedef enum logic [1:0] {
        IDLE,
        BOOT,
        WAIT_SLOT,
        RETIRE
    } retire_state_t;

endpackage

/* hdl/fetch_slot.sv */
`timescale 1ns/10ps

module fetch_slot
    import fetch_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  addr_t pc_i,
    input  addr_t snpc_i,
    input  logic  valid_i,
    input  inst_t rdata_i,
    input  logic  rvalid_i,
    output addr_t slot_pc_o,
    output addr_t slot_snpc_o,
    output inst_t slot_inst_o,
    output logic  slot_full_o
);

    logic capture;

    // word and its pc meet in the same cycle
    assign capture = rvalid_i && valid_i;

    always_ff @(posedge clock) begin
        if (capture) begin
            slot_pc_o   <= pc_i;
            slot_snpc_o <= snpc_i;
            slot_inst_o <= rdata_i;
        end
    end

    // one pulse per fetch
    always_ff @(posedge clock) begin
        if (reset) begin
            slot_full_o <= 1'b0;
        end else begin
            slot_full_o <= capture;
        end
    end

endmodule

/* hdl/fetch_top.sv */
`timescale 1ns/10ps

`include "fetch_consts.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   run_i,
    input  addr_t                  mtvec_i,
    input  logic                   load_en_i,
    input  logic [`IMEM_IDX_W-1:0] load_index_i,
    input  inst_t                  load_data_i,
    output logic                   retire_o,
    output addr_t                  retire_pc_o,
    output inst_t                  retire_inst_o,
    output logic [1:0]             retire_kind_o,
    output addr_t                  araddr_o,
    output logic                   arvalid_o
);

    logic      finish;
    redirect_t redirect;
    addr_t     mepc;
    logic      arready;
    inst_t     rdata;
    logic      rvalid;
    addr_t     pc;
    addr_t     snpc;
    logic      valid;
    addr_t     slot_pc;
    addr_t     slot_snpc;
    inst_t     slot_inst;
    logic      slot_full;

    ifu u_ifu (
        .clock         (clock),
        .reset         (reset),
        .wbu_finish_i  (finish),
        .wbu_ifu_bus_i (redirect),
        .csr_mtvec_i   (mtvec_i),
        .csr_mepc_i    (mepc),
        .arready_i     (arready),
        .pc_o          (pc),
        .snpc_o        (snpc),
        .valid_o       (valid),
        .araddr_o      (araddr_o),
        .arvalid_o     (arvalid_o)
    );

    imem u_imem (
        .clock        (clock),
        .reset        (reset),
        .load_en_i    (load_en_i),
        .load_index_i (load_index_i),
        .load_data_i  (load_data_i),
        .araddr_i     (araddr_o),
        .arvalid_i    (arvalid_o),
        .arready_o    (arready),
        .rdata_o      (rdata),
        .rvalid_o     (rvalid)
    );

    fetch_slot u_fetch_slot (
        .clock       (clock),
        .reset       (reset),
        .pc_i        (pc),
        .snpc_i      (snpc),
        .valid_i     (valid),
        .rdata_i     (rdata),
        .rvalid_i    (rvalid),
        .slot_pc_o   (slot_pc),
        .slot_snpc_o (slot_snpc),
        .slot_inst_o (slot_inst),
        .slot_full_o (slot_full)
    );

    flow_retire u_flow_retire (
        .clock         (clock),
        .reset         (reset),
        .run_i         (run_i),
        .slot_pc_i     (slot_pc),
        .slot_snpc_i   (slot_snpc),
        .slot_inst_i   (slot_inst),
        .slot_full_i   (slot_full),
        .wbu_finish_o  (finish),
        .wbu_ifu_bus_o (redirect),
        .csr_mepc_o    (mepc),
        .retire_o      (retire_o),
        .retire_pc_o   (retire_pc_o),
        .retire_inst_o (retire_inst_o),
        .retire_kind_o (retire_kind_o)
    );

endmodule

/* hdl/flow_retire.sv */
`timescale 1ns/10ps

`include "fetch_consts.svh"

module flow_retire
    import fetch_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       run_i,
    input  addr_t      slot_pc_i,
    input  addr_t      slot_snpc_i,
    input  inst_t      slot_inst_i,
    input  logic       slot_full_i,
    output logic       wbu_finish_o,
    output redirect_t  wbu_ifu_bus_o,
    output addr_t      csr_mepc_o,
    output logic       retire_o,
    output addr_t      retire_pc_o,
    output inst_t      retire_inst_o,
    output logic [1:0] retire_kind_o
);

    localparam logic [1:0] KIND_SEQ  = 2'd0;
    localparam logic [1:0] KIND_JUMP = 2'd1;
    localparam logic [1:0] KIND_EXCP = 2'd2;
    localparam logic [1:0] KIND_RET  = 2'd3;

    retire_state_t state;

    logic       run_q;
    logic       run_rise;
    logic       take;
    logic [6:0] opcode;
    logic       is_jal;
    logic       is_system;
    logic       is_ecall;
    logic       is_mret;
    addr_t      j_imm;
    addr_t      jal_target;
    logic [1:0] kind;
    addr_t      mepc;

    assign run_rise = run_i && !run_q;
    assign take     = (state == WAIT_SLOT) && slot_full_i;

    // control flow decode only
    assign opcode    = slot_inst_i[6:0];
    assign is_jal    = opcode == `OP_JAL;
    assign is_system = opcode == `OP_SYSTEM;
    assign is_ecall  = is_system && (slot_inst_i == `INST_ECALL);
    assign is_mret   = is_system && (slot_inst_i == `INST_MRET);

    // J-type immediate, bit 0 always zero
    assign j_imm = {{12{slot_inst_i[31]}}, slot_inst_i[19:12], slot_inst_i[20],
                    slot_inst_i[30:21], 1'b0};
    assign jal_target = slot_pc_i + j_imm;

    always_comb begin
        if (is_ecall) begin
            kind = KIND_EXCP;
        end else if (is_mret) begin
            kind = KIND_RET;
        end else if (is_jal) begin
            kind = KIND_JUMP;
        end else begin
            kind = KIND_SEQ;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            run_q <= 1'b0;
        end else begin
            run_q <= run_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (run_rise) begin
                        state <= BOOT;
                    end
                end
                BOOT:      state <= WAIT_SLOT;
                WAIT_SLOT: begin
                    if (slot_full_i) begin
                        state <= RETIRE;
                    end
                end
                RETIRE:    state <= WAIT_SLOT;
                default:   state <= IDLE;
            endcase
        end
    end

    // redirect held until the next finish
    always_ff @(posedge clock) begin
        if (reset) begin
            wbu_ifu_bus_o <= '0;
        end else if ((state == IDLE) && run_rise) begin
            wbu_ifu_bus_o <= '0;
        end else if (take) begin
            wbu_ifu_bus_o <= {is_ecall, is_mret, is_jal, jal_target};
        end
    end

    // mepc keeps the ecall pc itself, no +4
    always_ff @(posedge clock) begin
        if (reset) begin
            mepc <= `RESET_PC;
        end else if (take && is_ecall) begin
            mepc <= slot_pc_i;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            retire_pc_o   <= slot_pc_i;
            retire_inst_o <= slot_inst_i;
            retire_kind_o <= kind;
        end
    end

    assign wbu_finish_o = (state == BOOT) || (state == RETIRE);
    assign retire_o     = state == RETIRE;
    assign csr_mepc_o   = mepc;

endmodule

/* hdl/ifu.sv */
`timescale 1ns/10ps

`include "fetch_consts.svh"

module ifu
    import fetch_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      wbu_finish_i,
    input  redirect_t wbu_ifu_bus_i,
    input  addr_t     csr_mtvec_i,
    input  addr_t     csr_mepc_i,
    input  logic      arready_i,
    output addr_t     pc_o,
    output addr_t     snpc_o,
    output logic      valid_o,
    output addr_t     araddr_o,
    output logic      arvalid_o
);

    addr_t ifu_pc;
    addr_t snpc;
    addr_t dnpc;

    logic  excp_flush;
    logic  xret_flush;
    logic  jmp_flag;
    addr_t jmp_target;

    // request pending, held until arready
    logic  rreq;
    logic  valid;
    // first finish is the boot pulse, pc stays at reset value
    logic  started;

    assign snpc = ifu_pc + 32'd4;

    assign {excp_flush, xret_flush, jmp_flag, jmp_target} = wbu_ifu_bus_i;

    // next pc priority: exception, return, jump, sequential
    always_comb begin
        if (excp_flush) begin
            dnpc = csr_mtvec_i;
        end else if (xret_flush) begin
            dnpc = csr_mepc_i;
        end else if (jmp_flag) begin
            dnpc = jmp_target;
        end else begin
            dnpc = snpc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rreq    <= 1'b0;
            valid   <= 1'b0;
            started <= 1'b0;
            ifu_pc  <= `RESET_PC;
        end else if (rreq && arready_i) begin
            // handshake done, word arrives next to imem rvalid
            rreq  <= 1'b0;
            valid <= 1'b1;
        end else if (!rreq && wbu_finish_i) begin
            rreq    <= 1'b1;
            valid   <= 1'b0;
            started <= 1'b1;
            if (started) begin
                ifu_pc <= dnpc;
            end
        end
    end

    assign araddr_o  = ifu_pc;
    assign arvalid_o = rreq;

    assign pc_o    = ifu_pc;
    assign snpc_o  = snpc;
    assign valid_o = valid;

endmodule

/* hdl/imem.sv */
`timescale 1ns/10ps

`include "fetch_consts.svh"

module imem
    import fetch_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   load_en_i,
    input  logic [`IMEM_IDX_W-1:0] load_index_i,
    input  inst_t                  load_data_i,
    input  addr_t                  araddr_i,
    input  logic                   arvalid_i,
    output logic                   arready_o,
    output inst_t                  rdata_o,
    output logic                   rvalid_o
);

    inst_t mem [`IMEM_WORDS];

    addr_t                  offset;
    logic [`IMEM_IDX_W-1:0] rd_index;
    logic [3:0]             wait_cnt;

    // byte offset from the base, word index above bit 1
    assign offset   = araddr_i - `RESET_PC;
    assign rd_index = offset[`IMEM_IDX_W+1:2];

    // testbench load port
    always_ff @(posedge clock) begin
        if (load_en_i) begin
            mem[load_index_i] <= load_data_i;
        end
    end

    // arready after arvalid has been up for IMEM_WAIT cycles
    always_ff @(posedge clock) begin
        if (reset) begin
            arready_o <= 1'b0;
            wait_cnt  <= '0;
        end else if (arready_o) begin
            arready_o <= 1'b0;
            wait_cnt  <= '0;
        end else if (arvalid_i) begin
            if (wait_cnt == 4'(`IMEM_WAIT - 1)) begin
                arready_o <= 1'b1;
                wait_cnt  <= '0;
            end else begin
                wait_cnt <= wait_cnt + 4'd1;
            end
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= arvalid_i && arready_o;
        end
    end

    // read data is payload only
    always_ff @(posedge clock) begin
        if (arvalid_i && arready_o) begin
            rdata_o <= mem[rd_index];
        end
    end

endmodule

/* tb/fetch_top_properties.sv */
`timescale 1ns/10ps

module fetch_top_properties
    import fetch_pkg::*;
(
    input logic  clock,
    input logic  reset,
    input logic  arvalid_i,
    input addr_t araddr_i,
    input logic  arready_i,
    input logic  rvalid_i,
    input logic  retire_i
);

    logic handshake;

    assign handshake = arvalid_i && arready_i;

    // request held with the same address until accepted
    a_arvalid_hold: assert property (
        @(posedge clock) disable iff (reset)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i)
    ) else $error("arvalid dropped or araddr changed before arready");

    a_rvalid_after_handshake: assert property (
        @(posedge clock) disable iff (reset)
        handshake |=> rvalid_i
    ) else $error("no rvalid in the cycle after the handshake");

    // and never without one
    a_rvalid_only_after_handshake: assert property (
        @(posedge clock) disable iff (reset)
        rvalid_i |-> $past(handshake)
    ) else $error("rvalid without a handshake one cycle earlier");

    a_retire_pulse: assert property (
        @(posedge clock) disable iff (reset)
        retire_i |=> !retire_i
    ) else $error("retire_o high for more than one cycle");

endmodule

bind fetch_top fetch_top_properties u_properties (
    .clock     (clock),
    .reset     (reset),
    .arvalid_i (arvalid_o),
    .araddr_i  (araddr_o),
    .arready_i (arready),
    .rvalid_i  (rvalid),
    .retire_i  (retire_o)
);

/* tb/fetch_top_tb.sv */
`timescale 1ns/10ps

`include "fetch_consts.svh"

module fetch_top_tb;
    import fetch_pkg::*;

    localparam int NUM_TESTS    = 4;
    localparam int PROG_WORDS   = 16;
    localparam int IDLE_CYCLES  = 4;
    localparam int SETUP_CYCLES = 40;
    localparam int DRIVE_DELAY  = 10;

    logic                   clock;
    logic                   reset;
    logic                   run_i;
    addr_t                  mtvec_i;
    logic                   load_en_i;
    logic [`IMEM_IDX_W-1:0] load_index_i;
    inst_t                  load_data_i;
    logic                   retire_o;
    addr_t                  retire_pc_o;
    inst_t                  retire_inst_o;
    logic [1:0]             retire_kind_o;
    addr_t                  araddr_o;
    logic                   arvalid_o;

    // stimulus table, a zero word becomes random filler
    inst_t prog_table [NUM_TESTS][PROG_WORDS];
    // byte offset of each jal in the program
    int    jump_table [NUM_TESTS][PROG_WORDS];
    addr_t mtvec_table [NUM_TESTS];
    int    watch_table [NUM_TESTS];
    string name_table [NUM_TESTS];

    inst_t       prog_words [PROG_WORDS];
    logic [15:0] lfsr;
    logic        table_ready;
    logic        request_seen;
    int          error_count;
    int          check_count;

    fetch_top dut (
        .clock         (clock),
        .reset         (reset),
        .run_i         (run_i),
        .mtvec_i       (mtvec_i),
        .load_en_i     (load_en_i),
        .load_index_i  (load_index_i),
        .load_data_i   (load_data_i),
        .retire_o      (retire_o),
        .retire_pc_o   (retire_pc_o),
        .retire_inst_o (retire_inst_o),
        .retire_kind_o (retire_kind_o),
        .araddr_o      (araddr_o),
        .arvalid_o     (arvalid_o)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[15]};
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    // addi with random rd, rs1 and immediate
    task automatic make_filler(output inst_t word);
        logic [31:0] imm;
        logic [31:0] rs1;
        logic [31:0] rd;
        take_bits(12, imm);
        take_bits(5, rs1);
        take_bits(5, rd);
        word = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endtask

    // jal x1, offset
    function automatic inst_t encode_jal(input int offset);
        logic [20:0] imm;
        imm = 21'(offset);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `OP_JAL};
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int i = 0; i < PROG_WORDS; i++) begin
                prog_table[t][i] = '0;
                jump_table[t][i] = 0;
            end
        end
        name_table[0]  = "straight_line";
        mtvec_table[0] = `RESET_PC + 32'h30;
        watch_table[0] = 12;
        // 1 jumps ahead to 4, 5 jumps back to 1
        name_table[1]    = "jal_forward_backward";
        jump_table[1][1] = 12;
        jump_table[1][5] = -16;
        prog_table[1][1] = encode_jal(jump_table[1][1]);
        prog_table[1][5] = encode_jal(jump_table[1][5]);
        mtvec_table[1]   = `RESET_PC + 32'h30;
        watch_table[1]   = 10;
        name_table[2]    = "ecall_to_mtvec";
        prog_table[2][1] = `INST_ECALL;
        mtvec_table[2]   = `RESET_PC + 32'h20;
        watch_table[2]   = 6;
        // handler at word 10 returns to the ecall at word 2, the loop repeats
        name_table[3]     = "mret_to_ecall_pc";
        prog_table[3][2]  = `INST_ECALL;
        prog_table[3][11] = `INST_MRET;
        mtvec_table[3]    = `RESET_PC + 32'h28;
        watch_table[3]    = 9;
        table_ready = 1'b1;
    endtask

    task automatic reset_dut(input addr_t mtvec);
        @(posedge clock);
        #DRIVE_DELAY;
        reset     = 1'b1;
        run_i     = 1'b0;
        load_en_i = 1'b0;
        mtvec_i   = mtvec;
        repeat (8) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
    endtask

    task automatic load_program(input int test);
        inst_t word;
        for (int i = 0; i < PROG_WORDS; i++) begin
            if (prog_table[test][i] == '0) begin
                make_filler(word);
                prog_words[i] = word;
            end else begin
                prog_words[i] = prog_table[test][i];
            end
        end
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(posedge clock);
            #DRIVE_DELAY;
            load_en_i    = 1'b1;
            load_index_i = 6'(i);
            load_data_i  = prog_words[i];
        end
        @(posedge clock);
        #DRIVE_DELAY;
        load_en_i = 1'b0;
    endtask

    // counts rising edges up to the next retirement
    task automatic wait_retire(output int cycles);
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            @(negedge clock);
            if (arvalid_o && !request_seen) begin
                request_seen = 1'b1;
                check_value(araddr_o, `RESET_PC, "first araddr_o");
            end
        end while (!retire_o);
    endtask

    task automatic run_test(input int test);
        addr_t      model_pc;
        addr_t      model_mepc;
        addr_t      next_pc;
        addr_t      index;
        inst_t      word;
        logic [1:0] kind;
        int         cycles;
        int         expected_gap;
        int         errors_before;
        errors_before = error_count;
        reset_dut(mtvec_table[test]);
        load_program(test);
        // nothing moves before run_i rises
        repeat (IDLE_CYCLES) begin
            @(negedge clock);
            check_value(32'(retire_o), 32'd0, "retire_o before run_i");
            check_value(32'(arvalid_o), 32'd0, "arvalid_o before run_i");
        end
        request_seen = 1'b0;
        @(posedge clock);
        #DRIVE_DELAY;
        run_i      = 1'b1;
        model_pc   = `RESET_PC;
        model_mepc = `RESET_PC;
        for (int n = 0; n < watch_table[test]; n++) begin
            wait_retire(cycles);
            // the first one also spends the edge that samples run_i
            expected_gap = (n == 0) ? `IMEM_WAIT + 5 : `IMEM_WAIT + 4;
            check_value(32'(cycles), 32'(expected_gap), "cycles to retire_o");
            index = (model_pc - `RESET_PC) >> 2;
            if (index >= 32'(PROG_WORDS)) begin
                $display("reference model left the program at pc %h", model_pc);
                error_count++;
                break;
            end
            word = prog_words[index[3:0]];
            if (word == `INST_ECALL) begin
                kind       = 2'd2;
                model_mepc = model_pc;
                next_pc    = mtvec_table[test];
            end else if (word == `INST_MRET) begin
                kind    = 2'd3;
                next_pc = model_mepc;
            end else if (word[6:0] == `OP_JAL) begin
                kind    = 2'd1;
                next_pc = model_pc + 32'(jump_table[test][index[3:0]]);
            end else begin
                kind    = 2'd0;
                next_pc = model_pc + 32'd4;
            end
            check_value(retire_pc_o, model_pc, "retire_pc_o");
            check_value(retire_inst_o, word, "retire_inst_o");
            check_value(32'(retire_kind_o), 32'(kind), "retire_kind_o");
            model_pc = next_pc;
        end
        check_value(32'(request_seen), 32'd1, "arvalid_o after run_i");
        $display("test %0d %s: %0d retirements, %0d errors", test, name_table[test],
                 watch_table[test], error_count - errors_before);
    endtask

    initial begin
        reset        = 1'b1;
        run_i        = 1'b0;
        mtvec_i      = `RESET_PC;
        load_en_i    = 1'b0;
        load_index_i = '0;
        load_data_i  = '0;
        lfsr         = 16'd10;
        table_ready  = 1'b0;
        request_seen = 1'b0;
        error_count  = 0;
        check_count  = 0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog, two retire periods per watched retirement plus setup
    initial begin
        int budget;
        budget = 0;
        wait (table_ready);
        for (int t = 0; t < NUM_TESTS; t++) begin
            budget += watch_table[t] * (`IMEM_WAIT + 4) * 2 + SETUP_CYCLES;
        end
        repeat (budget) @(posedge clock);
        $display("run timed out after %0d cycles with no retirement", budget);
        $display("TEST FAILED");
        $finish;
    end

endmodule
